// ==== rtl/hazard_defs.svh ====
`ifndef HAZARD_DEFS_SVH
`define HAZARD_DEFS_SVH

// Data path and address width
`define HAZ_DATA_W 16

// Eight architectural registers
`define HAZ_REG_W 3

// Major opcode field in the top bits of the instruction
`define HAZ_OPC_W 5

// Younger stages tracked: ID, EX, MEM, WB
`define HAZ_DEPTH 4

`endif

// ==== rtl/hazardPkg.sv ====
`include "hazard_defs.svh"

package hazardPkg;

    // Instruction, immediate, register data and addresses
    typedef logic [`HAZ_DATA_W-1:0] dataWord;

    // Register file index
    typedef logic [`HAZ_REG_W-1:0] regIdx;

    // Major opcode
    typedef logic [`HAZ_OPC_W-1:0] opcode;

    // Fetch stage instruction after decode
    typedef struct packed {
        regIdx   rs;
        regIdx   rt;
        regIdx   rd;
        logic    writeEn;
        logic    memEnable;
        dataWord memAddr;
        logic    jumpOrBranch;
        logic    jumpReg;
        logic    nopInstr;
    } decodedInstr;

    // One in-flight instruction as seen by the hazard logic
    typedef struct packed {
        regIdx   rd;
        logic    writeEn;
        logic    memEnable;
        dataWord memAddr;
    } stageEntry;

    // Hazard comparator results
    typedef struct packed {
        logic regHaz;
        logic memHaz;
    } hazardFlags;

endpackage

// ==== rtl/instrDecoder.sv ====
`timescale 1ns/10ps
`include "hazard_defs.svh"

module instrDecoder (
    input  hazardPkg::dataWord     instr,
    input  hazardPkg::dataWord     imm,
    input  hazardPkg::dataWord     reg1Data,
    input  hazardPkg::regIdx       rd,
    input  logic                   writeEn,
    input  logic                   memEnable,
    output hazardPkg::decodedInstr decoded
);
    import hazardPkg::*;

    opcode   opc;
    dataWord effAddr;
    logic    isJumpReg;
    logic    isJumpBranch;
    logic    isNop;

    // Opcode is the top field
    assign opc = instr[`HAZ_DATA_W-1 -: `HAZ_OPC_W];

    // Register-indirect jumps
    always_comb begin
        case (opc)
            5'b00101, 5'b00111: isJumpReg = 1'b1;
            default:            isJumpReg = 1'b0;
        endcase
    end

    // Jumps are 001x_x, branches 011x_x
    always_comb begin
        case (opc[`HAZ_OPC_W-1 -: 3])
            3'b001:  isJumpBranch = 1'b1;
            3'b011:  isJumpBranch = 1'b1;
            default: isJumpBranch = 1'b0;
        endcase
    end

    assign isNop = (opc == 5'b00001);

    // Base plus offset, carry out dropped
    assign effAddr = reg1Data + imm;

    always_comb begin
        decoded.rs           = instr[`HAZ_DATA_W-`HAZ_OPC_W-1 -: `HAZ_REG_W];
        decoded.rt           = instr[`HAZ_DATA_W-`HAZ_OPC_W-`HAZ_REG_W-1 -: `HAZ_REG_W];
        decoded.rd           = rd;
        decoded.writeEn      = writeEn;
        decoded.memEnable    = memEnable;
        decoded.memAddr      = effAddr;
        decoded.jumpOrBranch = isJumpBranch;
        decoded.jumpReg      = isJumpReg;
        decoded.nopInstr     = isNop;
    end

endmodule

// ==== rtl/stageShadow.sv ====
`timescale 1ns/10ps
`include "hazard_defs.svh"

module stageShadow (
    input  logic                   clk,
    input  logic                   reset,
    input  hazardPkg::decodedInstr decoded,
    output hazardPkg::hazardFlags  flags
);
    import hazardPkg::*;

    // Slot 0 is ID, the top slot is WB
    stageEntry [`HAZ_DEPTH-1:0] history;
    stageEntry                  newEntry;

    logic [`HAZ_DEPTH-1:0] rsMatch;
    logic [`HAZ_DEPTH-1:0] rtMatch;
    logic [`HAZ_DEPTH-1:0] addrMatch;

    // What the current instruction leaves behind in the pipe
    always_comb begin
        newEntry.rd        = decoded.rd;
        newEntry.writeEn   = decoded.writeEn;
        newEntry.memEnable = decoded.memEnable;
        newEntry.memAddr   = decoded.memAddr;
    end

    // Shifts every cycle, stalls included
    always_ff @(posedge clk) begin
        if (reset) begin
            history <= '0;
        end else begin
            history <= {history[`HAZ_DEPTH-2:0], newEntry};
        end
    end

    // Per-stage comparators
    genvar i;
    generate
        for (i = 0; i < `HAZ_DEPTH; i++) begin : gCompare
            assign rsMatch[i] = history[i].writeEn && (history[i].rd == decoded.rs);
            assign rtMatch[i] = history[i].writeEn && (history[i].rd == decoded.rt);

            // Enable and address taken from the same stage
            assign addrMatch[i] = history[i].memEnable &&
                                  (history[i].memAddr == decoded.memAddr);
        end
    endgenerate

    // Any older writer of either source
    assign flags.regHaz = |(rsMatch | rtMatch);

    // Only a memory access can collide with one in flight
    assign flags.memHaz = decoded.memEnable && (|addrMatch);

endmodule

// ==== rtl/bubbleControl.sv ====
`timescale 1ns/10ps

module bubbleControl (
    input  logic                   clk,
    input  logic                   reset,
    input  hazardPkg::decodedInstr decoded,
    input  hazardPkg::hazardFlags  flags,
    output logic                   nop,
    output logic                   pcStall
);

    logic jrPrev;
    logic prevJumpBranch;
    logic anyHaz;
    logic noopAfterJr;

    assign anyHaz = flags.regHaz | flags.memHaz;

    // Jump history for next-cycle bubbles
    always_ff @(posedge clk) begin
        if (reset) begin
            jrPrev         <= 1'b0;
            prevJumpBranch <= 1'b0;
        end else begin
            jrPrev <= decoded.jumpReg;
            // A stalled jump is replayed, so no bubble is owed yet
            prevJumpBranch <= decoded.jumpOrBranch & ~anyHaz;
        end
    end

    // No-op following a register jump fills the slot itself
    assign noopAfterJr = decoded.nopInstr & jrPrev;

    assign nop = (anyHaz | prevJumpBranch | decoded.jumpReg) & ~noopAfterJr;

    // A no-op never holds the PC
    assign pcStall = anyHaz & ~decoded.nopInstr;

endmodule

// ==== rtl/hazardUnit.sv ====
`timescale 1ns/10ps

module hazardUnit (
    input  logic               clk,
    input  logic               reset,
    input  hazardPkg::dataWord instr,
    input  hazardPkg::dataWord imm,
    input  hazardPkg::dataWord reg1Data,
    input  hazardPkg::regIdx   rd,
    input  logic               writeEn,
    input  logic               memEnable,
    output logic               nop,
    output logic               pcStall
);
    import hazardPkg::*;

    decodedInstr decoded;
    hazardFlags  flags;

    // Field split, opcode class and effective address
    instrDecoder instrDecoder_i (
        .instr     (instr),
        .imm       (imm),
        .reg1Data  (reg1Data),
        .rd        (rd),
        .writeEn   (writeEn),
        .memEnable (memEnable),
        .decoded   (decoded)
    );

    // History of ID, EX, MEM and WB plus comparators
    stageShadow stageShadow_i (
        .clk     (clk),
        .reset   (reset),
        .decoded (decoded),
        .flags   (flags)
    );

    // Bubble and PC hold
    bubbleControl bubbleControl_i (
        .clk     (clk),
        .reset   (reset),
        .decoded (decoded),
        .flags   (flags),
        .nop     (nop),
        .pcStall (pcStall)
    );

endmodule

// ==== tb/hazardUnit_assertions.sv ====
`timescale 1ns/10ps

module hazardUnit_assertions (
    input logic                   clk,
    input logic                   reset,
    input hazardPkg::decodedInstr decoded,
    input hazardPkg::hazardFlags  flags,
    input logic                   nop,
    input logic                   pcStall
);

    int stallFails = 0;
    int resetFails = 0;
    int jumpFails  = 0;
    int failCount;

    assign failCount = stallFails + resetFails + jumpFails;

    // A held PC always comes with a bubble
    stallWithBubble: assert property (@(posedge clk) disable iff (reset)
        (pcStall && !decoded.nopInstr) |-> nop)
        else begin
            $error("pcStall raised without nop");
            stallFails = stallFails + 1;
        end

    // Cleared history, only a register jump can bubble
    quietAfterReset: assert property (@(posedge clk)
        $fell(reset) |-> (!pcStall && (nop == decoded.jumpReg)))
        else begin
            $error("output raised in first cycle after reset");
            resetFails = resetFails + 1;
        end

    // Taken jump or branch owes one bubble
    bubbleAfterJump: assert property (@(posedge clk) disable iff (reset)
        (decoded.jumpOrBranch && !flags.regHaz && !flags.memHaz) |=>
        (nop || (decoded.nopInstr && $past(decoded.jumpReg))))
        else begin
            $error("no bubble after stall-free jump or branch");
            jumpFails = jumpFails + 1;
        end

endmodule

// ==== tb/hazardChecker.sv ====
`timescale 1ns/10ps
`include "hazard_defs.svh"

module hazardChecker (
    input  logic               clk,
    input  logic               reset,
    input  hazardPkg::dataWord instr,
    input  hazardPkg::dataWord imm,
    input  hazardPkg::dataWord reg1Data,
    input  hazardPkg::regIdx   rd,
    input  logic               writeEn,
    input  logic               memEnable,
    input  logic               nop,
    input  logic               pcStall,
    input  int                 testId,
    input  logic               testDone,
    output int                 mismatches,
    output int                 testsPassed,
    output int                 testsFailed
);
    import hazardPkg::*;

    // Model history, index 0 is the youngest stage
    regIdx   mRd   [`HAZ_DEPTH];
    logic    mWe   [`HAZ_DEPTH];
    logic    mMem  [`HAZ_DEPTH];
    dataWord mAddr [`HAZ_DEPTH];
    logic    mJrPrev;
    logic    mJbPrev;

    int errTotal   = 0;
    int passCount  = 0;
    int failCount  = 0;
    int testCycles = 0;
    int testErrors = 0;

    assign mismatches  = errTotal;
    assign testsPassed = passCount;
    assign testsFailed = failCount;

    // Outputs are still the pre-edge values here
    always @(posedge clk) begin : model
        opcode   opc;
        regIdx   rs;
        regIdx   rt;
        dataWord addr;
        logic    regHaz;
        logic    memHaz;
        logic    jumpReg;
        logic    noopInstr;
        logic    jumpBranch;
        logic    expNop;
        logic    expStall;

        if (reset) begin
            for (int i = 0; i < `HAZ_DEPTH; i++) begin
                mRd[i]   = '0;
                mWe[i]   = 1'b0;
                mMem[i]  = 1'b0;
                mAddr[i] = '0;
            end
            mJrPrev = 1'b0;
            mJbPrev = 1'b0;
        end else begin
            opc  = instr[15:11];
            rs   = instr[10:8];
            rt   = instr[7:5];
            addr = reg1Data + imm;

            jumpReg    = (opc == 5'b00101) || (opc == 5'b00111);
            noopInstr  = (opc == 5'b00001);
            jumpBranch = (opc[4:2] == 3'b001) || (opc[4:2] == 3'b011);

            regHaz = 1'b0;
            memHaz = 1'b0;
            for (int i = 0; i < `HAZ_DEPTH; i++) begin
                if (mWe[i] && ((mRd[i] == rs) || (mRd[i] == rt))) regHaz = 1'b1;
                if (memEnable && mMem[i] && (mAddr[i] == addr)) memHaz = 1'b1;
            end

            expStall = (regHaz || memHaz) && !noopInstr;
            expNop   = (regHaz || memHaz || mJbPrev || jumpReg) && !(noopInstr && mJrPrev);

            if (nop !== expNop) begin
                $display("ERR %0t nop expected %0b actual %0b", $time, expNop, nop);
                testErrors++;
                errTotal++;
            end
            if (pcStall !== expStall) begin
                $display("ERR %0t pcStall expected %0b actual %0b", $time, expStall, pcStall);
                testErrors++;
                errTotal++;
            end
            testCycles++;

            // Advance ID to EX to MEM to WB
            for (int i = `HAZ_DEPTH - 1; i > 0; i--) begin
                mRd[i]   = mRd[i-1];
                mWe[i]   = mWe[i-1];
                mMem[i]  = mMem[i-1];
                mAddr[i] = mAddr[i-1];
            end
            mRd[0]   = rd;
            mWe[0]   = writeEn;
            mMem[0]  = memEnable;
            mAddr[0] = addr;
            mJrPrev  = jumpReg;
            mJbPrev  = jumpBranch && !regHaz && !memHaz;
        end

        if (testDone) begin
            if (testErrors == 0) begin
                passCount++;
                $display("test %0d: %0d cycles checked, ok", testId, testCycles);
            end else begin
                failCount++;
                $display("test %0d: %0d cycles checked, %0d mismatches, FAIL",
                         testId, testCycles, testErrors);
            end
            testCycles = 0;
            testErrors = 0;
        end
    end

endmodule

// ==== tb/hazardUnit_tb.sv ====
`timescale 1ns/10ps

module hazardUnit_tb;
    import hazardPkg::*;

    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 3;
    localparam logic [31:0] SEED         = 32'd38463;
    localparam int          NUM_TESTS    = 6;

    localparam int REG_RAW_CYCLES = 60;
    localparam int MEM_RAW_CYCLES = 60;
    localparam int JUMP_CYCLES    = 60;
    localparam int JR_CYCLES      = 60;
    localparam int RESET_SPLIT    = 20;
    localparam int MID_RESET      = 2;
    localparam int MIXED_CYCLES   = 400;

    // Each test also spends two cycles on its end marker
    localparam int TOTAL_CYCLES = RESET_CYCLES + REG_RAW_CYCLES + MEM_RAW_CYCLES
        + JUMP_CYCLES + JR_CYCLES + 2 * RESET_SPLIT + MID_RESET + MIXED_CYCLES
        + 2 * NUM_TESTS + 2;
    localparam int WATCHDOG_NS = (TOTAL_CYCLES + 100) * CLK_PERIOD;

    logic        clk = 1'b0;
    logic        reset;
    dataWord     instr;
    dataWord     imm;
    dataWord     reg1Data;
    regIdx       rd;
    logic        writeEn;
    logic        memEnable;
    logic        nop;
    logic        pcStall;
    int          testId;
    logic        testDone;
    int          mismatches;
    int          testsPassed;
    int          testsFailed;
    logic [31:0] lcgState;
    logic [4:0]  opcPool [$];

    hazardUnit hazardUnit_i (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .imm       (imm),
        .reg1Data  (reg1Data),
        .rd        (rd),
        .writeEn   (writeEn),
        .memEnable (memEnable),
        .nop       (nop),
        .pcStall   (pcStall)
    );

    bind hazardUnit hazardUnit_assertions assertChecks (
        .clk     (clk),
        .reset   (reset),
        .decoded (decoded),
        .flags   (flags),
        .nop     (nop),
        .pcStall (pcStall)
    );

    hazardChecker hazardChecker_i (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .imm         (imm),
        .reg1Data    (reg1Data),
        .rd          (rd),
        .writeEn     (writeEn),
        .memEnable   (memEnable),
        .nop         (nop),
        .pcStall     (pcStall),
        .testId      (testId),
        .testDone    (testDone),
        .mismatches  (mismatches),
        .testsPassed (testsPassed),
        .testsFailed (testsFailed)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [15:0] lcg();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[31:16];
    endfunction

    function automatic int randBelow(input int n);
        return int'(lcg()) % n;
    endfunction

    // Narrow spans make register and address matches likely
    task automatic applyInstr(input logic [4:0] opc, input int regSpan, input int weChance,
                              input int meChance, input int addrSpan);
        @(negedge clk);
        instr     = {opc, 3'(randBelow(regSpan)), 3'(randBelow(regSpan)), 5'(lcg())};
        rd        = 3'(randBelow(regSpan));
        writeEn   = (randBelow(100) < weChance);
        memEnable = (randBelow(100) < meChance);
        reg1Data  = 16'h0100 + 16'(randBelow(addrSpan));
        imm       = 16'(randBelow(addrSpan));
    endtask

    // Empty pool means any opcode
    task automatic runCycles(input int cycles, input int regSpan, input int weChance,
                             input int meChance, input int addrSpan);
        logic [4:0] opc;
        repeat (cycles) begin
            if (opcPool.size() == 0) opc = 5'(lcg());
            else opc = opcPool[randBelow(opcPool.size())];
            applyInstr(opc, regSpan, weChance, meChance, addrSpan);
        end
    endtask

    task automatic holdReset(input int cycles);
        @(negedge clk);
        reset = 1'b1;
        repeat (cycles) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic finishTest();
        @(negedge clk);
        testDone = 1'b1;
        @(negedge clk);
        testDone = 1'b0;
        testId   = testId + 1;
    endtask

    initial begin
        int assertFails;
        lcgState  = SEED;
        reset     = 1'b1;
        instr     = '0;
        imm       = '0;
        reg1Data  = '0;
        rd        = '0;
        writeEn   = 1'b0;
        memEnable = 1'b0;
        testId    = 1;
        testDone  = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // Register RAW with ALU opcodes only
        opcPool = {5'b00000, 5'b01000, 5'b10000, 5'b11000};
        runCycles(REG_RAW_CYCLES, 4, 50, 0, 1);
        finishTest();

        // Memory RAW without register writes
        runCycles(MEM_RAW_CYCLES, 8, 0, 50, 4);
        finishTest();

        // Jumps and branches mixed with some hazards
        opcPool = {5'b00100, 5'b00110, 5'b01100, 5'b01111, 5'b00000, 5'b10000};
        runCycles(JUMP_CYCLES, 4, 30, 20, 2);
        finishTest();

        // Register jumps followed by no-ops
        opcPool = {5'b00101, 5'b00111, 5'b00001, 5'b00001, 5'b00000};
        runCycles(JR_CYCLES, 2, 30, 0, 1);
        finishTest();

        // Reset in the middle of a hazard-rich stream
        opcPool = {5'b00000, 5'b10000, 5'b00100};
        runCycles(RESET_SPLIT, 2, 60, 50, 2);
        holdReset(MID_RESET);
        runCycles(RESET_SPLIT, 2, 60, 50, 2);
        finishTest();

        opcPool.delete();
        runCycles(MIXED_CYCLES, 8, 50, 50, 8);
        finishTest();

        repeat (2) @(negedge clk);
        assertFails = hazardUnit_i.assertChecks.failCount;
        $display("summary: %0d tests ok, %0d tests failing, %0d mismatches, %0d assertion fails",
                 testsPassed, testsFailed, mismatches, assertFails);
        if (mismatches == 0 && testsFailed == 0 && testsPassed == NUM_TESTS
            && assertFails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before all tests finished", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+rtl
rtl/hazardPkg.sv
rtl/instrDecoder.sv
rtl/stageShadow.sv
rtl/bubbleControl.sv
rtl/hazardUnit.sv
tb/hazardUnit_assertions.sv
tb/hazardChecker.sv
tb/hazardUnit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

TOP=hazardUnit_tb
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f filelist.f --top-module "$TOP" --Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
    echo "no verdict found in $LOG"
    exit 1
fi
exit 0
